// File: c16_loader.f
+incdir+src
src/c16_loader_pkg.sv
src/c16_loader_decode.sv
src/c16_loader_execute.sv
src/c16_loader_zp_shadow.sv
src/c16_loader.sv
verification/c16_loader_properties.sv
verification/c16_loader_tb.sv

// File: run.sh
#!/bin/sh
# build the c16 loader testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f c16_loader.f \
	--top-module c16_loader_tb -o c16_loader_sim || { echo "build failed"; exit 1; }

./obj_dir/c16_loader_sim > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }

// File: verification/c16_loader_tb.sv
// --------------------
// c16 loader testbench
// random host files and cpu overlay accesses, checked against a model
// --------------------
`timescale 1ns/10ps
`include "c16_loader_config.svh"

module c16_loader_tb;

	localparam int TIMEOUT = 200;

	logic clk28 = 1'b0;
	logic reset;
	logic ioctl_downloading_i;
	c16_loader_pkg::dl_index_t ioctl_index_i;
	logic ioctl_wr_i;
	c16_loader_pkg::mem_addr_t ioctl_addr_i;
	c16_loader_pkg::byte_t ioctl_data_i;
	logic clkref_i;
	c16_loader_pkg::cpu_addr_t cpu_addr_i;
	logic cpu_cas_n_i;
	logic cpu_rw_i;
	c16_loader_pkg::byte_t cpu_dout_i;
	logic mem_wr_o;
	c16_loader_pkg::mem_addr_t mem_addr_o;
	c16_loader_pkg::byte_t mem_data_o;
	logic cpu_wait_o;
	logic zp_hit_o;
	c16_loader_pkg::byte_t zp_dout_o;

	// model state
	c16_loader_pkg::mem_addr_t model_addr;
	c16_loader_pkg::mem_addr_t exp_addr_q[$];
	c16_loader_pkg::byte_t exp_data_q[$];
	c16_loader_pkg::cpu_addr_t model_ptr [4];
	int errors;
	int timeouts;
	int writes_seen;
	int slot_cnt;
	logic wr_q;

	c16_loader u_c16_loader (
		.clk28               ( clk28               ),
		.reset               ( reset               ),
		.ioctl_downloading_i ( ioctl_downloading_i ),
		.ioctl_index_i       ( ioctl_index_i       ),
		.ioctl_wr_i          ( ioctl_wr_i          ),
		.ioctl_addr_i        ( ioctl_addr_i        ),
		.ioctl_data_i        ( ioctl_data_i        ),
		.clkref_i            ( clkref_i            ),
		.cpu_addr_i          ( cpu_addr_i          ),
		.cpu_cas_n_i         ( cpu_cas_n_i         ),
		.cpu_rw_i            ( cpu_rw_i            ),
		.cpu_dout_i          ( cpu_dout_i          ),
		.mem_wr_o            ( mem_wr_o            ),
		.mem_addr_o          ( mem_addr_o          ),
		.mem_data_o          ( mem_data_o          ),
		.cpu_wait_o          ( cpu_wait_o          ),
		.zp_hit_o            ( zp_hit_o            ),
		.zp_dout_o           ( zp_dout_o           )
	);

	bind c16_loader c16_loader_properties u_properties (
		.clk28      ( clk28      ),
		.reset      ( reset      ),
		.clkref_i   ( clkref_i   ),
		.mem_wr_o   ( mem_wr_o   ),
		.mem_addr_o ( mem_addr_o )
	);

	always #5 clk28 = ~clk28;

	// slot phase, eight cycles per half
	always @(posedge clk28) begin
		#1;
		if (slot_cnt == 7) begin
			slot_cnt = 0;
			clkref_i = ~clkref_i;
		end else begin
			slot_cnt = slot_cnt + 1;
		end
	end

	// --------------------
	// write monitor
	// --------------------

	// compare each rising strobe with the next expected byte
	task automatic check_write();
		c16_loader_pkg::mem_addr_t ea;
		c16_loader_pkg::byte_t ed;
		writes_seen++;
		if (exp_addr_q.size() == 0) begin
			$display("write to %h with no byte outstanding at time %0t", mem_addr_o, $time);
			errors++;
		end else begin
			ea = exp_addr_q.pop_front();
			ed = exp_data_q.pop_front();
			if (mem_addr_o != ea) begin
				$display("[ERROR] time %0t: mem_addr_o expected %h got %h", $time, ea, mem_addr_o);
				errors++;
			end
			if (mem_data_o != ed) begin
				$display("[ERROR] time %0t: mem_data_o expected %h got %h", $time, ed, mem_data_o);
				errors++;
			end
		end
	endtask

	always @(negedge clk28) begin
		if (reset) begin
			wr_q = 1'b0;
		end else begin
			if (mem_wr_o && !wr_q) begin
				check_write();
			end
			wr_q = mem_wr_o;
		end
	end

	// --------------------
	// helpers
	// --------------------
	function automatic c16_loader_pkg::cpu_addr_t ptr_base(int k);
		case (k)
			0: return `C16L_ZP_PTR0;
			1: return `C16L_ZP_PTR1;
			2: return `C16L_ZP_PTR2;
			default: return `C16L_ZP_PTR3;
		endcase
	endfunction

	function automatic logic is_ptr(c16_loader_pkg::cpu_addr_t a);
		logic hit;
		hit = 1'b0;
		for (int k = 0; k < 4; k++) begin
			if (a == ptr_base(k) || a == ptr_base(k) + 16'd1) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// bytes go out just after the cpu slot opens, one per slot
	task automatic wait_slot_start();
		logic prev;
		int n;
		n = 0;
		@(negedge clk28);
		prev = clkref_i;
		@(negedge clk28);
		while (!(clkref_i && !prev) && n < TIMEOUT) begin
			prev = clkref_i;
			@(negedge clk28);
			n++;
		end
		if (n >= TIMEOUT) begin
			$display("timed out waiting for the cpu slot to start");
			timeouts++;
		end
	endtask

	task automatic send_byte(c16_loader_pkg::mem_addr_t offset, c16_loader_pkg::byte_t d);
		wait_slot_start();
		@(posedge clk28);
		#1;
		ioctl_wr_i = 1'b1;
		ioctl_addr_i = offset;
		ioctl_data_i = d;
		@(posedge clk28);
		#1;
		ioctl_wr_i = 1'b0;
	endtask

	task automatic expect_write(c16_loader_pkg::mem_addr_t a, c16_loader_pkg::byte_t d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	// all expected writes seen and the last strobe gone, then a quiet slot
	task automatic drain_writes();
		int n;
		n = 0;
		@(negedge clk28);
		while ((exp_addr_q.size() != 0 || mem_wr_o) && n < TIMEOUT) begin
			@(negedge clk28);
			n++;
		end
		if (n >= TIMEOUT) begin
			$display("timed out with %0d writes still missing", exp_addr_q.size());
			timeouts++;
		end
		repeat (20) @(negedge clk28);
	endtask

	task automatic start_download(c16_loader_pkg::dl_index_t idx);
		logic exp_wait;
		exp_wait = (idx == `C16L_IDX_PRG) || (idx == `C16L_IDX_BASIC) ||
			(idx == `C16L_IDX_KERNAL);
		@(posedge clk28);
		#1;
		ioctl_index_i = idx;
		ioctl_downloading_i = 1'b1;
		@(negedge clk28);
		if (cpu_wait_o != exp_wait) begin
			$display("[ERROR] time %0t: cpu_wait_o expected %b got %b",
				$time, exp_wait, cpu_wait_o);
			errors++;
		end
	endtask

	task automatic end_download();
		drain_writes();
		@(posedge clk28);
		#1;
		ioctl_downloading_i = 1'b0;
		@(negedge clk28);
		if (cpu_wait_o != 1'b0) begin
			$display("[ERROR] time %0t: cpu_wait_o expected 0 got %b", $time, cpu_wait_o);
			errors++;
		end
	endtask

	task automatic check_overlay(c16_loader_pkg::cpu_addr_t a, logic exp_hit,
			c16_loader_pkg::byte_t exp_d);
		@(posedge clk28);
		#1;
		cpu_addr_i = a;
		@(negedge clk28);
		if (zp_hit_o != exp_hit) begin
			$display("[ERROR] time %0t: zp_hit_o at %h expected %b got %b",
				$time, a, exp_hit, zp_hit_o);
			errors++;
		end
		if (zp_dout_o != exp_d) begin
			$display("[ERROR] time %0t: zp_dout_o at %h expected %h got %h",
				$time, a, exp_d, zp_dout_o);
			errors++;
		end
	endtask

	task automatic check_pointers();
		for (int k = 0; k < 4; k++) begin
			check_overlay(ptr_base(k), 1'b1, model_ptr[k][7:0]);
			check_overlay(ptr_base(k) + 16'd1, 1'b1, model_ptr[k][15:8]);
		end
	endtask

	// cas low with write level, held past the delayed write pulse
	task automatic cpu_write(c16_loader_pkg::cpu_addr_t a, c16_loader_pkg::byte_t d);
		@(posedge clk28);
		#1;
		cpu_addr_i = a;
		cpu_dout_i = d;
		cpu_rw_i = 1'b0;
		cpu_cas_n_i = 1'b0;
		repeat (3) @(posedge clk28);
		#1;
		cpu_cas_n_i = 1'b1;
		cpu_rw_i = 1'b1;
	endtask

	// --------------------
	// test sequences
	// --------------------
	task automatic load_prg();
		c16_loader_pkg::byte_t lo;
		c16_loader_pkg::byte_t hi;
		c16_loader_pkg::byte_t d;
		int n;
		lo = 8'($urandom);
		hi = 8'($urandom);
		n = 3 + $urandom % 6;
		start_download(`C16L_IDX_PRG);
		send_byte(0, lo);
		send_byte(1, hi);
		model_addr = {9'd0, hi, lo};
		for (int i = 0; i < n; i++) begin
			d = 8'($urandom);
			expect_write(model_addr, d);
			model_addr = model_addr + 25'd1;
			send_byte(25'(2 + i), d);
		end
		end_download();
		// end pointers sit one past the byte after the program
		for (int k = 0; k < 4; k++) begin
			model_ptr[k] = model_addr[15:0] + 16'd1;
		end
		repeat (5) @(posedge clk28);
		check_pointers();
	endtask

	// tape and kernal files store every byte from a fixed base
	task automatic load_linear(c16_loader_pkg::dl_index_t idx, c16_loader_pkg::mem_addr_t base);
		c16_loader_pkg::byte_t d;
		int n;
		n = 3 + $urandom % 6;
		start_download(idx);
		model_addr = base;
		for (int i = 0; i < n; i++) begin
			d = 8'($urandom);
			expect_write(model_addr, d);
			model_addr = model_addr + 25'd1;
			send_byte(25'(i), d);
		end
		end_download();
	endtask

	task automatic load_basic();
		c16_loader_pkg::byte_t d;
		int skip;
		int n;
		skip = 2 + $urandom % 4;
		n = 2 + $urandom % 5;
		start_download(`C16L_IDX_BASIC);
		// drive image part, nothing may reach memory
		for (int i = 0; i < skip; i++) begin
			send_byte(25'(i), 8'($urandom));
		end
		drain_writes();
		model_addr = `C16L_ROM_MEM_START;
		for (int i = 0; i < n; i++) begin
			d = 8'($urandom);
			expect_write(model_addr, d);
			model_addr = model_addr + 25'd1;
			send_byte(`C16L_BASIC_SKIP_END + 25'(i), d);
		end
		end_download();
	endtask

	// indices 0x10..0x3f are not known files
	task automatic load_unknown();
		c16_loader_pkg::dl_index_t idx;
		idx = 8'h10 + 8'($urandom % 48);
		start_download(idx);
		for (int i = 0; i < 4; i++) begin
			send_byte(25'(i), 8'($urandom));
		end
		end_download();
	endtask

	task automatic overlay_test();
		c16_loader_pkg::cpu_addr_t a;
		c16_loader_pkg::byte_t d;
		int k;
		int b;
		for (int i = 0; i < 8; i++) begin
			k = $urandom % 4;
			b = $urandom % 2;
			d = 8'($urandom);
			a = ptr_base(k) + 16'(b);
			cpu_write(a, d);
			if (b == 1) begin
				model_ptr[k][15:8] = d;
			end else begin
				model_ptr[k][7:0] = d;
			end
			check_overlay(a, 1'b1, d);
		end
		check_pointers();
		// misses, half of them inside zero page
		for (int i = 0; i < 8; i++) begin
			a = 16'($urandom);
			if (i % 2 == 0) begin
				a[15:8] = 8'h00;
			end
			if (!is_ptr(a)) begin
				check_overlay(a, 1'b0, 8'hFF);
			end
		end
	endtask

	initial begin
		void'($urandom(55));
		errors = 0;
		timeouts = 0;
		writes_seen = 0;
		slot_cnt = 0;
		wr_q = 1'b0;
		reset = 1'b1;
		clkref_i = 1'b1;
		ioctl_downloading_i = 1'b0;
		ioctl_index_i = '0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		cpu_addr_i = '0;
		cpu_cas_n_i = 1'b1;
		cpu_rw_i = 1'b1;
		cpu_dout_i = '0;
		for (int k = 0; k < 4; k++) begin
			model_ptr[k] = '0;
		end
		repeat (2) @(posedge clk28);
		#1;
		reset = 1'b0;

		check_pointers();
		overlay_test();
		load_prg();
		load_linear(`C16L_IDX_TAP, `C16L_TAP_MEM_START);
		load_linear(`C16L_IDX_KERNAL, `C16L_ROM_MEM_START);
		load_basic();
		load_unknown();
		load_prg();
		overlay_test();

		$display("errors %0d, timeouts %0d, writes %0d", errors, timeouts, writes_seen);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: verification/c16_loader_properties.sv
// --------------------
// c16 loader properties
// slot timing and write strobe checks on the host memory port
// --------------------
`timescale 1ns/10ps

module c16_loader_properties (
	input logic                      clk28,
	input logic                      reset,
	input logic                      clkref_i,
	input logic                      mem_wr_o,
	input c16_loader_pkg::mem_addr_t mem_addr_o
);

	// once the cpu slot has run a full cycle the strobe must be gone
	wr_outside_cpu_slot: assert property (@(posedge clk28) disable iff (reset)
		(clkref_i && $past(clkref_i)) |-> !mem_wr_o)
		else $error("mem_wr_o high inside the cpu slot");

	// first rising clkref ends the write
	wr_ends_at_cpu_slot: assert property (@(posedge clk28) disable iff (reset)
		(clkref_i && !$past(clkref_i)) |=> !mem_wr_o)
		else $error("mem_wr_o still high after the cpu slot started");

	// address held for the whole strobe
	addr_stable_in_wr: assert property (@(posedge clk28) disable iff (reset)
		(mem_wr_o && $past(mem_wr_o)) |-> $stable(mem_addr_o))
		else $error("mem_addr_o changed while mem_wr_o was high");

endmodule

// File: src/c16_loader.sv
// --------------------
// c16 memory loader
// injects host files into shared memory and keeps the basic end
// pointers in step with a loaded program
// --------------------
`timescale 1ns/10ps

module c16_loader (
	input  logic                        clk28,
	input  logic                        reset,

	// host download stream
	input  logic                        ioctl_downloading_i,
	input  c16_loader_pkg::dl_index_t   ioctl_index_i,
	input  logic                        ioctl_wr_i,
	input  c16_loader_pkg::mem_addr_t   ioctl_addr_i,
	input  c16_loader_pkg::byte_t       ioctl_data_i,

	// memory slot phase, high is the cpu slot
	input  logic                        clkref_i,

	// cpu side
	input  c16_loader_pkg::cpu_addr_t   cpu_addr_i,
	input  logic                        cpu_cas_n_i,
	input  logic                        cpu_rw_i,
	input  c16_loader_pkg::byte_t       cpu_dout_i,

	// host half of the memory port
	output logic                        mem_wr_o,
	output c16_loader_pkg::mem_addr_t   mem_addr_o,
	output c16_loader_pkg::byte_t       mem_data_o,

	output logic                        cpu_wait_o,
	output logic                        zp_hit_o,
	output c16_loader_pkg::byte_t       zp_dout_o
);

	// --------------------
	// decode to execute
	// --------------------

	logic load_lo;
	logic load_hi;
	logic start_tap;
	logic start_rom;
	logic store_req;

	// end of prg download into the shadow
	logic prg_done;

	c16_loader_decode u_decode (
		.clk28               ( clk28               ),
		.reset               ( reset               ),
		.ioctl_downloading_i ( ioctl_downloading_i ),
		.ioctl_index_i       ( ioctl_index_i       ),
		.ioctl_wr_i          ( ioctl_wr_i          ),
		.ioctl_addr_i        ( ioctl_addr_i        ),
		.dl_kind_o           (                     ),
		.load_lo_o           ( load_lo             ),
		.load_hi_o           ( load_hi             ),
		.start_tap_o         ( start_tap           ),
		.start_rom_o         ( start_rom           ),
		.store_req_o         ( store_req           ),
		.prg_done_o          ( prg_done            ),
		.cpu_wait_o          ( cpu_wait_o          )
	);

	c16_loader_execute u_execute (
		.clk28        ( clk28        ),
		.reset        ( reset        ),
		.clkref_i     ( clkref_i     ),
		.ioctl_data_i ( ioctl_data_i ),
		.load_lo_i    ( load_lo      ),
		.load_hi_i    ( load_hi      ),
		.start_tap_i  ( start_tap    ),
		.start_rom_i  ( start_rom    ),
		.store_req_i  ( store_req    ),
		.mem_wr_o     ( mem_wr_o     ),
		.mem_addr_o   ( mem_addr_o   ),
		.mem_data_o   ( mem_data_o   )
	);

	// load address doubles as the program end address
	c16_loader_zp_shadow u_zp_shadow (
		.clk28       ( clk28       ),
		.reset       ( reset       ),
		.cpu_addr_i  ( cpu_addr_i  ),
		.cpu_cas_n_i ( cpu_cas_n_i ),
		.cpu_rw_i    ( cpu_rw_i    ),
		.cpu_dout_i  ( cpu_dout_i  ),
		.prg_done_i  ( prg_done    ),
		.end_addr_i  ( mem_addr_o  ),
		.zp_hit_o    ( zp_hit_o    ),
		.zp_dout_o   ( zp_dout_o   )
	);

endmodule

// File: src/c16_loader_zp_shadow.sv
// --------------------
// c16 zero-page shadow
// four basic end pointers overlaid on cpu memory, written by the cpu
// or set from the load address when a program finishes loading
// --------------------
`timescale 1ns/10ps
`include "c16_loader_config.svh"

module c16_loader_zp_shadow (
	input  logic                        clk28,
	input  logic                        reset,
	input  c16_loader_pkg::cpu_addr_t   cpu_addr_i,
	input  logic                        cpu_cas_n_i,
	input  logic                        cpu_rw_i,
	input  c16_loader_pkg::byte_t       cpu_dout_i,
	input  logic                        prg_done_i,
	input  c16_loader_pkg::mem_addr_t   end_addr_i,
	output logic                        zp_hit_o,
	output c16_loader_pkg::byte_t       zp_dout_o
);

	localparam int NPTR = 4;

	// low byte addresses, the high byte follows each one
	localparam c16_loader_pkg::cpu_addr_t ZP_LO [NPTR] = '{
		`C16L_ZP_PTR0,
		`C16L_ZP_PTR1,
		`C16L_ZP_PTR2,
		`C16L_ZP_PTR3
	};

	c16_loader_pkg::cpu_addr_t ptr [NPTR];
	logic [NPTR-1:0] sel_lo;
	logic [NPTR-1:0] sel_hi;
	logic cas_n_q;
	logic wr_pulse;

	// address match against all eight bytes
	always_comb begin
		for (int i = 0; i < NPTR; i++) begin
			sel_lo[i] = cpu_addr_i == ZP_LO[i];
			sel_hi[i] = cpu_addr_i == ZP_LO[i] + 16'd1;
		end
	end

	assign zp_hit_o = |{sel_lo, sel_hi};

	// overlay read, open bus value on a miss
	always_comb begin
		zp_dout_o = 8'hFF;
		for (int i = 0; i < NPTR; i++) begin
			if (sel_lo[i]) begin
				zp_dout_o = ptr[i][7:0];
			end
			if (sel_hi[i]) begin
				zp_dout_o = ptr[i][15:8];
			end
		end
	end

	// write pulse one cycle after cas falls, address has settled by then
	always_ff @(posedge clk28) begin
		if (reset) begin
			cas_n_q <= 1'b1;
			wr_pulse <= 1'b0;
			for (int i = 0; i < NPTR; i++) begin
				ptr[i] <= '0;
			end
		end else begin
			cas_n_q <= cpu_cas_n_i;
			wr_pulse <= cas_n_q && !cpu_cas_n_i;
			if (prg_done_i) begin
				// all four point just past the loaded program
				for (int i = 0; i < NPTR; i++) begin
					ptr[i] <= end_addr_i[`C16L_CPU_AW-1:0] + 16'd1;
				end
			end else if (wr_pulse && !cpu_rw_i) begin
				for (int i = 0; i < NPTR; i++) begin
					if (sel_lo[i]) begin
						ptr[i][7:0] <= cpu_dout_i;
					end
					if (sel_hi[i]) begin
						ptr[i][15:8] <= cpu_dout_i;
					end
				end
			end
		end
	end

endmodule

// File: src/c16_loader_execute.sv
// --------------------
// c16 loader execute
// owns the load address and one pending byte, writes it in the host
// half of the memory slot and steps the address afterwards
// --------------------
`timescale 1ns/10ps
`include "c16_loader_config.svh"

module c16_loader_execute (
	input  logic                        clk28,
	input  logic                        reset,
	input  logic                        clkref_i,
	input  c16_loader_pkg::byte_t       ioctl_data_i,
	input  logic                        load_lo_i,
	input  logic                        load_hi_i,
	input  logic                        start_tap_i,
	input  logic                        start_rom_i,
	input  logic                        store_req_i,
	output logic                        mem_wr_o,
	output c16_loader_pkg::mem_addr_t   mem_addr_o,
	output c16_loader_pkg::byte_t       mem_data_o
);

	// high half of the prg load address, upper bits stay zero
	localparam int HI_PAD = `C16L_MEM_AW - 8 - `C16L_BYTE_W;

	logic clkref_q;
	logic pending;
	logic slot_host;
	logic slot_cpu;

	// --------------------
	// slot edges
	// --------------------

	// clkref high is the cpu slot, low belongs to the host
	always_ff @(posedge clk28) begin
		if (reset) begin
			clkref_q <= 1'b0;
		end else begin
			clkref_q <= clkref_i;
		end
	end

	// falling edge opens the host slot
	assign slot_host = clkref_q && !clkref_i;
	// rising edge hands memory back to the cpu
	assign slot_cpu = !clkref_q && clkref_i;

	// --------------------
	// address, pending byte and write strobe
	// --------------------
	always_ff @(posedge clk28) begin
		if (reset) begin
			pending <= 1'b0;
			mem_wr_o <= 1'b0;
			mem_addr_o <= '0;
		end else begin
			// byte is in flight, drop the request
			if (mem_wr_o) begin
				pending <= 1'b0;
			end

			// header and start actions from decode
			if (load_lo_i) begin
				mem_addr_o[7:0] <= ioctl_data_i;
			end
			if (load_hi_i) begin
				mem_addr_o[`C16L_MEM_AW-1:8] <= {{HI_PAD{1'b0}}, ioctl_data_i};
			end
			if (start_tap_i) begin
				mem_addr_o <= `C16L_TAP_MEM_START;
			end
			if (start_rom_i) begin
				mem_addr_o <= `C16L_ROM_MEM_START;
			end

			// a second byte before the slot merges into the first
			if (store_req_i) begin
				pending <= 1'b1;
			end

			// one write per host slot
			if (slot_host) begin
				mem_wr_o <= pending;
			end

			// write done, next byte goes one higher
			if (slot_cpu) begin
				if (mem_wr_o) begin
					mem_addr_o <= mem_addr_o + 1'b1;
				end
				mem_wr_o <= 1'b0;
			end
		end
	end

	// data must still be stable from the host at the slot edge
	always_ff @(posedge clk28) begin
		if (slot_host && pending) begin
			mem_data_o <= ioctl_data_i;
		end
	end

endmodule

// File: src/c16_loader_decode.sv
// --------------------
// c16 loader decode
// classifies the host file index and turns byte strobes into address
// actions and store requests, flags the end of a program download
// --------------------
`timescale 1ns/10ps
`include "c16_loader_config.svh"

module c16_loader_decode (
	input  logic                        clk28,
	input  logic                        reset,
	input  logic                        ioctl_downloading_i,
	input  c16_loader_pkg::dl_index_t   ioctl_index_i,
	input  logic                        ioctl_wr_i,
	input  c16_loader_pkg::mem_addr_t   ioctl_addr_i,
	output c16_loader_pkg::dl_kind_e    dl_kind_o,
	output logic                        load_lo_o,
	output logic                        load_hi_o,
	output logic                        start_tap_o,
	output logic                        start_rom_o,
	output logic                        store_req_o,
	output logic                        prg_done_o,
	output logic                        cpu_wait_o
);

	logic is_basic;
	logic is_kernal;
	logic is_first;
	logic prg_dl_d1;
	logic prg_dl_d2;

	assign is_basic = ioctl_index_i == `C16L_IDX_BASIC;
	assign is_kernal = ioctl_index_i == `C16L_IDX_KERNAL;
	assign is_first = ioctl_addr_i == '0;

	// kind follows the level, none outside a download
	always_comb begin
		dl_kind_o = c16_loader_pkg::DL_NONE;
		if (ioctl_downloading_i) begin
			case (ioctl_index_i)
				`C16L_IDX_PRG: dl_kind_o = c16_loader_pkg::DL_PRG;
				`C16L_IDX_TAP: dl_kind_o = c16_loader_pkg::DL_TAP;
				`C16L_IDX_BASIC,
				`C16L_IDX_KERNAL: dl_kind_o = c16_loader_pkg::DL_ROM;
				default: dl_kind_o = c16_loader_pkg::DL_NONE;
			endcase
		end
	end

	// prg header, first two bytes carry the load address
	assign load_lo_o = ioctl_wr_i && (dl_kind_o == c16_loader_pkg::DL_PRG) && is_first;
	assign load_hi_o = ioctl_wr_i && (dl_kind_o == c16_loader_pkg::DL_PRG) &&
		(ioctl_addr_i == c16_loader_pkg::mem_addr_t'(1));

	assign start_tap_o = ioctl_wr_i && (dl_kind_o == c16_loader_pkg::DL_TAP) && is_first;

	// kernal starts at once, combined rom only past the drive image
	assign start_rom_o = ioctl_wr_i && (dl_kind_o == c16_loader_pkg::DL_ROM) &&
		((is_kernal && is_first) || (is_basic && ioctl_addr_i == `C16L_BASIC_SKIP_END));

	always_comb begin
		case (dl_kind_o)
			c16_loader_pkg::DL_PRG:
				store_req_o = ioctl_wr_i && (ioctl_addr_i > c16_loader_pkg::mem_addr_t'(1));
			c16_loader_pkg::DL_TAP:
				store_req_o = ioctl_wr_i;
			// drive rom part of the combined file is never stored
			c16_loader_pkg::DL_ROM:
				store_req_o = ioctl_wr_i && (is_kernal || ioctl_addr_i[16:14] != 3'd0);
			default:
				store_req_o = 1'b0;
		endcase
	end

	// cpu is held off while its memory image is replaced
	assign cpu_wait_o = (dl_kind_o == c16_loader_pkg::DL_PRG) ||
		(dl_kind_o == c16_loader_pkg::DL_ROM);

	// end of prg download, two delay stages then a registered falling edge
	always_ff @(posedge clk28) begin
		if (reset) begin
			prg_dl_d1 <= 1'b0;
			prg_dl_d2 <= 1'b0;
			prg_done_o <= 1'b0;
		end else begin
			prg_dl_d1 <= dl_kind_o == c16_loader_pkg::DL_PRG;
			prg_dl_d2 <= prg_dl_d1;
			prg_done_o <= prg_dl_d2 && !prg_dl_d1;
		end
	end

endmodule

// File: src/c16_loader_pkg.sv
// --------------------
// c16 loader types
// vector types for addresses and bytes, and the download kind
// --------------------
`include "c16_loader_config.svh"

package c16_loader_pkg;

	// shared memory address, covers rom and tape areas
	typedef logic [`C16L_MEM_AW-1:0] mem_addr_t;

	// one data byte on host or cpu side
	typedef logic [`C16L_BYTE_W-1:0] byte_t;

	// host file index
	typedef logic [`C16L_BYTE_W-1:0] dl_index_t;

	// full cpu address after ras/cas demux
	typedef logic [`C16L_CPU_AW-1:0] cpu_addr_t;

	// kind of the download in progress
	typedef enum logic [1:0] {
		DL_NONE,
		DL_PRG,
		DL_TAP,
		DL_ROM
	} dl_kind_e;

endpackage

// File: src/c16_loader_config.svh
// --------------------
// c16 loader configuration
// memory bases, host file indices, zero-page pointer addresses and widths
// --------------------
`ifndef C16_LOADER_CONFIG_SVH
`define C16_LOADER_CONFIG_SVH

// bus widths
`define C16L_MEM_AW 25
`define C16L_BYTE_W 8
`define C16L_CPU_AW 16

// memory bases for injected images
`define C16L_ROM_MEM_START 25'h0010000
`define C16L_TAP_MEM_START 25'h0020000

// host file indices
`define C16L_IDX_BASIC 8'h00
`define C16L_IDX_PRG 8'h01
`define C16L_IDX_KERNAL 8'h03
`define C16L_IDX_TAP 8'h41

// combined rom starts with the 16k drive image, storing begins after it
`define C16L_BASIC_SKIP_END 25'h0004000

// low bytes of the basic end pointers, high byte sits one above
`define C16L_ZP_PTR0 16'h002D
`define C16L_ZP_PTR1 16'h002F
`define C16L_ZP_PTR2 16'h0031
`define C16L_ZP_PTR3 16'h009D

`endif
